// ==== build.f ====
logic/div_pkg.sv
logic/div_shift_sub.sv
logic/div_regs.sv
logic/div_apb_top.sv
sim/div_assertions.sv
sim/div_checker.sv
sim/div_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the divider testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f build.f --top-module div_tb \
   --Mdir obj_dir -o div_sim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

# keep running after an assertion error so the testbench prints its summary
./obj_dir/div_sim +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "SIMULATION FAILED" "$LOG"; then
   exit 1
fi
if ! grep -q "SIMULATION PASSED" "$LOG"; then
   echo "simulation ended without a result"
   exit 1
fi
exit 0

// ==== sim/div_tb.sv ====
`timescale 1ns/1ns

module div_tb;
   import div_pkg::*;

   localparam int N_DIRECTED = 7;
   localparam int N_RANDOM   = 8;
   localparam int N_ROWS     = N_DIRECTED + N_RANDOM;
   localparam int N_TESTS    = N_ROWS + 2;  // busy and bus error tests too
   localparam int WATCHDOG_CYCLES = N_TESTS * (DATA_W + 20) + 50;
   localparam logic [DATA_W-1:0] ONES = '1;

   logic              clk;
   logic              arst;
   logic              psel;
   logic              penable;
   logic              pwrite;
   logic [ADDR_W-1:0] paddr;
   logic [DATA_W-1:0] pwdata;
   logic [DATA_W-1:0] prdata;
   logic              pready;
   logic              pslverr;

   // stimulus table
   string             row_name [N_ROWS];
   logic [DATA_W-1:0] row_a    [N_ROWS];
   logic [DATA_W-1:0] row_b    [N_ROWS];
   logic [DATA_W-1:0] row_q    [N_ROWS];
   logic [DATA_W-1:0] row_r    [N_ROWS];

   always #10 clk = ~clk;

   div_apb_top dut (
      .clk_i     (clk),
      .arst_i    (arst),
      .psel_i    (psel),
      .penable_i (penable),
      .pwrite_i  (pwrite),
      .paddr_i   (paddr),
      .pwdata_i  (pwdata),
      .prdata_o  (prdata),
      .pready_o  (pready),
      .pslverr_o (pslverr)
   );

   div_checker u_chk (
      .clk_i     (clk),
      .arst_i    (arst),
      .psel_i    (psel),
      .penable_i (penable),
      .pwrite_i  (pwrite),
      .paddr_i   (paddr),
      .prdata_i  (prdata),
      .pready_i  (pready),
      .pslverr_i (pslverr)
   );

   bind div_shift_sub div_assertions u_assert (
      .clk_i   (clk_i),
      .arst_i  (arst_i),
      .start_i (start_i),
      .busy_i  (busy_o),
      .done_i  (done_o),
      .state_i (state_q),
      .step_i  (step_q)
   );

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   task automatic set_row(input int i, input string name, input logic [DATA_W-1:0] a,
                          input logic [DATA_W-1:0] b, input logic [DATA_W-1:0] q,
                          input logic [DATA_W-1:0] r);
      row_name[i] = name;
      row_a[i]    = a;
      row_b[i]    = b;
      row_q[i]    = q;
      row_r[i]    = r;
   endtask

   task automatic build_table();
      logic [31:0]       seed;
      logic [DATA_W-1:0] a, b, q, r;
      set_row(0, "div_100_7", 32'd100, 32'd7, 32'd14, 32'd2);
      set_row(1, "div_0_5", 32'd0, 32'd5, 32'd0, 32'd0);
      set_row(2, "div_5_9", 32'd5, 32'd9, 32'd0, 32'd5);
      set_row(3, "div_ones_1", ONES, 32'd1, ONES, 32'd0);
      set_row(4, "div_ones_ones", ONES, ONES, 32'd1, 32'd0);
      set_row(5, "div_1_ones", 32'd1, ONES, 32'd0, 32'd1);
      set_row(6, "div_by_zero", 32'd1234, 32'd0, ONES, 32'd1234);
      seed = 32'h78c94164;
      for (int i = N_DIRECTED; i < N_ROWS; i++) begin
         seed = lcg_next(seed);
         a    = seed;
         seed = lcg_next(seed);
         b    = seed >> seed[4:0];  // spread the divisor sizes
         if (b == '0) begin
            q = ONES;
            r = a;
         end else begin
            q = a / b;
            r = a % b;
         end
         set_row(i, $sformatf("random_%0d", i - N_DIRECTED), a, b, q, r);
      end
   endtask

   task automatic apb_write(input string name, input logic [ADDR_W-1:0] addr,
                            input logic [DATA_W-1:0] data, input logic exp_err);
      @(negedge clk);
      u_chk.expect_access(name, '0, 1'b0, exp_err);
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = 1'b1;
      paddr   = addr;
      pwdata  = data;
      @(negedge clk);
      penable = 1'b1;
      @(negedge clk);  // access edge lies in between
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   task automatic apb_read(input string name, input logic [ADDR_W-1:0] addr,
                           input logic [DATA_W-1:0] exp_data, input logic check_data,
                           input logic exp_err, output logic [DATA_W-1:0] data);
      @(negedge clk);
      u_chk.expect_access(name, exp_data, check_data, exp_err);
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = 1'b0;
      paddr   = addr;
      @(negedge clk);
      penable = 1'b1;
      @(posedge clk);
      data    = prdata;
      @(negedge clk);
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   task automatic wait_done(input string name);
      logic [DATA_W-1:0] st;
      int                polls;
      st    = '0;
      polls = 0;
      while (!st[1] && polls < DATA_W) begin
         apb_read(name, REG_STATUS, '0, 1'b0, 1'b0, st);
         polls++;
      end
      if (!st[1]) begin
         u_chk.note_error(name, "done flag never set after start");
      end
   endtask

   task automatic check_identity(input string name, input logic [DATA_W-1:0] a,
                                 input logic [DATA_W-1:0] b, input logic [DATA_W-1:0] q,
                                 input logic [DATA_W-1:0] r);
      logic [2*DATA_W-1:0] sum;
      sum = {{DATA_W{1'b0}}, q} * {{DATA_W{1'b0}}, b} + {{DATA_W{1'b0}}, r};
      if (sum != {{DATA_W{1'b0}}, a} || r >= b) begin
         u_chk.note_error(name, "quotient times divisor plus remainder misses the dividend");
      end
   endtask

   task automatic run_row(input int i);
      logic [DATA_W-1:0] q;
      logic [DATA_W-1:0] r;
      apb_write(row_name[i], REG_DIVIDEND, row_a[i], 1'b0);
      apb_write(row_name[i], REG_DIVISOR, row_b[i], 1'b0);
      apb_write(row_name[i], REG_CTRL, 32'd1, 1'b0);
      wait_done(row_name[i]);
      apb_read(row_name[i], REG_QUOTIENT, row_q[i], 1'b1, 1'b0, q);
      apb_read(row_name[i], REG_REMAINDER, row_r[i], 1'b1, 1'b0, r);
      if (i >= N_DIRECTED && row_b[i] != '0) begin
         check_identity(row_name[i], row_a[i], row_b[i], q, r);
      end
      u_chk.finish_test(row_name[i]);
   endtask

   // writes during a run are refused and leave the operands alone
   task automatic busy_test();
      string             name;
      logic [DATA_W-1:0] d;
      name = "busy_protect";
      apb_write(name, REG_DIVIDEND, 32'd1000, 1'b0);
      apb_write(name, REG_DIVISOR, 32'd3, 1'b0);
      apb_write(name, REG_CTRL, 32'd1, 1'b0);
      apb_read(name, REG_STATUS, 32'd1, 1'b1, 1'b0, d);  // busy 1, done 0
      apb_write(name, REG_DIVISOR, 32'd5, 1'b1);
      apb_write(name, REG_CTRL, 32'd1, 1'b1);
      wait_done(name);
      apb_read(name, REG_QUOTIENT, 32'd333, 1'b1, 1'b0, d);
      apb_read(name, REG_REMAINDER, 32'd1, 1'b1, 1'b0, d);
      apb_read(name, REG_STATUS, 32'd2, 1'b1, 1'b0, d);
      apb_read(name, REG_DIVISOR, 32'd3, 1'b1, 1'b0, d);
      u_chk.finish_test(name);
   endtask

   task automatic bus_error_test();
      string             name;
      logic [DATA_W-1:0] d;
      name = "bus_errors";
      apb_read(name, 5'h1C, '0, 1'b0, 1'b1, d);  // unmapped
      apb_write(name, REG_QUOTIENT, 32'h1234_5678, 1'b1);
      apb_read(name, REG_QUOTIENT, 32'd333, 1'b1, 1'b0, d);
      apb_write(name, REG_DIVIDEND, 32'hCAFE_0123, 1'b0);
      apb_read(name, REG_DIVIDEND, 32'hCAFE_0123, 1'b1, 1'b0, d);
      u_chk.finish_test(name);
   endtask

   task automatic report_summary();
      int total;
      total = u_chk.errors + dut.u_div.u_assert.fail_cnt;
      $display("%0d tests, %0d failed, %0d checks, %0d errors, %0d assertion failures",
               u_chk.tests_run, u_chk.tests_failed, u_chk.checks, u_chk.errors,
               dut.u_div.u_assert.fail_cnt);
      if (total == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   endtask

   initial begin
      clk     = 1'b0;
      arst    = 1'b1;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
      paddr   = '0;
      pwdata  = '0;
      build_table();
      repeat (8) @(posedge clk);
      @(negedge clk);
      arst = 1'b0;
      for (int i = 0; i < N_ROWS; i++) begin
         run_row(i);
      end
      busy_test();
      bus_error_test();
      report_summary();
   end

   // watchdog
   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("Timeout: the tests did not finish within %0d clock cycles", WATCHDOG_CYCLES);
      $display("SIMULATION FAILED");
      $finish;
   end

endmodule

// ==== sim/div_checker.sv ====
`timescale 1ns/1ns

module div_checker (
   input logic                       clk_i,
   input logic                       arst_i,
   input logic                       psel_i,
   input logic                       penable_i,
   input logic                       pwrite_i,
   input logic [div_pkg::ADDR_W-1:0] paddr_i,
   input logic [div_pkg::DATA_W-1:0] prdata_i,
   input logic                       pready_i,
   input logic                       pslverr_i
);
   import div_pkg::*;

   // expectation for the next access phase
   string             exp_name;
   logic [DATA_W-1:0] exp_data;
   logic              exp_check;  // compare read data as well
   logic              exp_err;
   logic              armed = 1'b0;

   int checks       = 0;
   int errors       = 0;
   int test_errors  = 0;
   int tests_run    = 0;
   int tests_failed = 0;

   task automatic expect_access(input string name, input logic [DATA_W-1:0] data,
                                input logic check_data, input logic err);
      exp_name  = name;
      exp_data  = data;
      exp_check = check_data;
      exp_err   = err;
      armed     = 1'b1;
   endtask

   task automatic note_error(input string name, input string msg);
      $display("Error in %s: %s", name, msg);
      errors++;
      test_errors++;
   endtask

   task automatic finish_test(input string name);
      tests_run++;
      if (test_errors == 0) begin
         $display("Pass %s", name);
      end else begin
         tests_failed++;
         $display("Done %s with %0d errors", name, test_errors);
      end
      test_errors = 0;
   endtask

   // compare on every access edge
   always @(posedge clk_i) begin
      if (!arst_i && psel_i && penable_i) begin
         if (!armed) begin
            note_error("bus", "transfer seen with no expected response posted");
         end else begin
            checks++;
            if (pready_i !== 1'b1) begin
               note_error(exp_name, "pready was low in the access phase");
            end
            if (pslverr_i !== exp_err) begin
               $display("Fail %s: pslverr at 0x%02h expected %0b actual %0b",
                        exp_name, paddr_i, exp_err, pslverr_i);
               errors++;
               test_errors++;
            end
            if (!pwrite_i && exp_check && (prdata_i !== exp_data)) begin
               $display("Fail %s: read at 0x%02h expected 0x%08h actual 0x%08h",
                        exp_name, paddr_i, exp_data, prdata_i);
               errors++;
               test_errors++;
            end
         end
         armed = 1'b0;  // one expectation per transfer
      end
   end

endmodule

// ==== sim/div_assertions.sv ====
`timescale 1ns/1ns

module div_assertions (
   input logic                      clk_i,
   input logic                      arst_i,
   input logic                      start_i,
   input logic                      busy_i,
   input logic                      done_i,
   input div_pkg::div_state_e       state_i,
   input logic [div_pkg::CNT_W-1:0] step_i
);
   import div_pkg::*;

   int fail_cnt = 0;  // read by the testbench at the end

   // the register block must hold back a start during a run
   a_start_idle: assert property (@(posedge clk_i) disable iff (arst_i)
      start_i |-> !busy_i)
      else begin
         $error("start reached the divider while busy");
         fail_cnt++;
      end

   a_done_pulse: assert property (@(posedge clk_i) disable iff (arst_i)
      done_i |=> !done_i)
      else begin
         $error("done lasted longer than one cycle");
         fail_cnt++;
      end

   // busy high for exactly DATA_W samples, done comes with the fall
   a_busy_len: assert property (@(posedge clk_i) disable iff (arst_i)
      $fell(busy_i) |-> done_i && $past(busy_i, DATA_W) && !$past(busy_i, DATA_W + 1))
      else begin
         $error("busy did not last exactly DATA_W cycles");
         fail_cnt++;
      end

   a_step_range: assert property (@(posedge clk_i) disable iff (arst_i)
      (state_i == DIV_RUN) |-> (step_i < CNT_W'(DATA_W)))
      else begin
         $error("step counter out of range during a run");
         fail_cnt++;
      end

endmodule

// ==== logic/div_apb_top.sv ====
`timescale 1ns/1ns

module div_apb_top (
   input  logic                       clk_i,
   input  logic                       arst_i,
   input  logic                       psel_i,
   input  logic                       penable_i,
   input  logic                       pwrite_i,
   input  logic [div_pkg::ADDR_W-1:0] paddr_i,
   input  logic [div_pkg::DATA_W-1:0] pwdata_i,
   output logic [div_pkg::DATA_W-1:0] prdata_o,
   output logic                       pready_o,
   output logic                       pslverr_o
);
   import div_pkg::*;

   // regs to core
   logic              start;
   logic [DATA_W-1:0] dividend;
   logic [DATA_W-1:0] divisor;

   // core to regs
   logic              busy;
   logic              done;
   logic [DATA_W-1:0] quotient;
   logic [DATA_W-1:0] remainder;

   div_regs u_regs (
      .clk_i       (clk_i),
      .arst_i      (arst_i),
      .psel_i      (psel_i),
      .penable_i   (penable_i),
      .pwrite_i    (pwrite_i),
      .paddr_i     (paddr_i),
      .pwdata_i    (pwdata_i),
      .prdata_o    (prdata_o),
      .pready_o    (pready_o),
      .pslverr_o   (pslverr_o),
      .busy_i      (busy),
      .done_i      (done),
      .quotient_i  (quotient),
      .remainder_i (remainder),
      .start_o     (start),
      .dividend_o  (dividend),
      .divisor_o   (divisor)
   );

   div_shift_sub u_div (
      .clk_i       (clk_i),
      .arst_i      (arst_i),
      .start_i     (start),
      .dividend_i  (dividend),
      .divisor_i   (divisor),
      .busy_o      (busy),
      .done_o      (done),
      .quotient_o  (quotient),
      .remainder_o (remainder)
   );

endmodule

// ==== logic/div_regs.sv ====
`timescale 1ns/1ns

module div_regs (
   input  logic                       clk_i,
   input  logic                       arst_i,

   // apb slave
   input  logic                       psel_i,
   input  logic                       penable_i,
   input  logic                       pwrite_i,
   input  logic [div_pkg::ADDR_W-1:0] paddr_i,
   input  logic [div_pkg::DATA_W-1:0] pwdata_i,
   output logic [div_pkg::DATA_W-1:0] prdata_o,
   output logic                       pready_o,
   output logic                       pslverr_o,

   // divider core
   input  logic                       busy_i,
   input  logic                       done_i,
   input  logic [div_pkg::DATA_W-1:0] quotient_i,
   input  logic [div_pkg::DATA_W-1:0] remainder_i,
   output logic                       start_o,
   output logic [div_pkg::DATA_W-1:0] dividend_o,
   output logic [div_pkg::DATA_W-1:0] divisor_o
);
   import div_pkg::*;

   reg_sel_e          sel;
   logic              access;
   logic              wr_ok;      // write that passes the error check
   logic              err;

   logic [DATA_W-1:0] dividend_q;
   logic [DATA_W-1:0] divisor_q;
   logic [DATA_W-1:0] quotient_q;
   logic [DATA_W-1:0] remainder_q;
   logic              done_q;     // sticky until the next start

   assign sel    = reg_sel_e'(paddr_i);
   assign access = psel_i & penable_i;

   // error decode
   always_comb begin
      err = 1'b0;
      case (sel)
         REG_DIVIDEND,
         REG_DIVISOR,
         REG_CTRL:      err = pwrite_i & busy_i;  // operands locked during a run
         REG_STATUS,
         REG_QUOTIENT,
         REG_REMAINDER: err = pwrite_i;           // read only
         default:       err = 1'b1;               // unmapped
      endcase
   end

   assign pslverr_o = access & err;
   assign pready_o  = 1'b1;  // no wait states
   assign wr_ok     = access & pwrite_i & ~err;

   // a ctrl write while busy is refused by err
   assign start_o = wr_ok & (sel == REG_CTRL) & pwdata_i[0];

   // operand registers
   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         dividend_q <= '0;
         divisor_q  <= '0;
      end else if (wr_ok) begin
         if (sel == REG_DIVIDEND) dividend_q <= pwdata_i;
         if (sel == REG_DIVISOR)  divisor_q  <= pwdata_i;
      end
   end

   // result latches, taken when the core pulses done
   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         quotient_q  <= '0;
         remainder_q <= '0;
      end else if (done_i) begin
         quotient_q  <= quotient_i;
         remainder_q <= remainder_i;
      end
   end

   // sticky done
   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         done_q <= 1'b0;
      end else if (start_o) begin
         done_q <= 1'b0;  // a new run wins over a finishing one
      end else if (done_i) begin
         done_q <= 1'b1;
      end
   end

   // read mux, valid during the access phase
   always_comb begin
      prdata_o = '0;
      case (sel)
         REG_DIVIDEND:  prdata_o = dividend_q;
         REG_DIVISOR:   prdata_o = divisor_q;
         REG_STATUS:    prdata_o = {{(DATA_W - 2){1'b0}}, done_q, busy_i};
         REG_QUOTIENT:  prdata_o = quotient_q;
         REG_REMAINDER: prdata_o = remainder_q;
         default:       prdata_o = '0;  // ctrl and holes read as zero
      endcase
   end

   assign dividend_o = dividend_q;
   assign divisor_o  = divisor_q;

endmodule

// ==== logic/div_shift_sub.sv ====
`timescale 1ns/1ns

module div_shift_sub (
   input  logic                       clk_i,
   input  logic                       arst_i,
   input  logic                       start_i,
   input  logic [div_pkg::DATA_W-1:0] dividend_i,
   input  logic [div_pkg::DATA_W-1:0] divisor_i,
   output logic                       busy_o,
   output logic                       done_o,
   output logic [div_pkg::DATA_W-1:0] quotient_o,
   output logic [div_pkg::DATA_W-1:0] remainder_o
);
   import div_pkg::*;

   div_state_e        state_q;
   logic [CNT_W-1:0]  step_q;     // steps taken in this run
   logic [2*DATA_W:0] rq_q;       // partial remainder on top, dividend/quotient below
   logic [DATA_W-1:0] divisor_q;
   logic              done_q;

   logic [2*DATA_W:0] rq_shift;
   logic [DATA_W+1:0] trial;
   logic              last_step;

   // shift first, then try to subtract from the upper part
   assign rq_shift  = {rq_q[2*DATA_W-1:0], 1'b0};
   assign trial     = {1'b0, rq_shift[2*DATA_W:DATA_W]} - {2'b00, divisor_q};
   assign last_step = (step_q == CNT_W'(DATA_W - 1));

   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         state_q   <= DIV_IDLE;
         step_q    <= '0;
         rq_q      <= '0;
         divisor_q <= '0;
         done_q    <= 1'b0;
      end else begin
         done_q <= 1'b0;  // single cycle pulse
         case (state_q)
            DIV_IDLE: begin
               if (start_i) begin
                  rq_q      <= {{(DATA_W + 1){1'b0}}, dividend_i};
                  divisor_q <= divisor_i;
                  step_q    <= '0;
                  state_q   <= DIV_RUN;
               end
            end
            DIV_RUN: begin
               // msb of trial set means the subtraction borrowed
               if (!trial[DATA_W+1]) begin
                  rq_q <= {trial[DATA_W:0], rq_shift[DATA_W-1:1], 1'b1};
               end else begin
                  rq_q <= rq_shift;  // restore, quotient bit 0
               end
               step_q <= step_q + 1'b1;
               if (last_step) begin
                  state_q <= DIV_IDLE;
                  done_q  <= 1'b1;
               end
            end
         endcase
      end
   end

   assign busy_o      = (state_q == DIV_RUN);
   assign done_o      = done_q;

   // results hold in idle until the next start
   assign quotient_o  = rq_q[DATA_W-1:0];
   assign remainder_o = rq_q[2*DATA_W-1:DATA_W];

endmodule

// ==== logic/div_pkg.sv ====
package div_pkg;

   // operand and result width
   localparam int DATA_W = 32;

   // apb byte address, offsets reach 0x14
   localparam int ADDR_W = 5;

   // step counter of the divider core
   localparam int CNT_W = $clog2(DATA_W) + 1;

   // register offsets, also used as bus opcodes
   typedef enum logic [ADDR_W-1:0] {
      REG_DIVIDEND  = 5'h00,
      REG_DIVISOR   = 5'h04,
      REG_CTRL      = 5'h08,  // write only, bit 0 starts a division
      REG_STATUS    = 5'h0C,  // bit 0 busy, bit 1 done
      REG_QUOTIENT  = 5'h10,
      REG_REMAINDER = 5'h14
   } reg_sel_e;

   // divider core states
   typedef enum logic {
      DIV_IDLE = 1'b0,
      DIV_RUN  = 1'b1
   } div_state_e;

endpackage
